/* verilog/src_params.svh */
`ifndef SRC_PARAMS_SVH
`define SRC_PARAMS_SVH

// datapath widths
`define SRC_SAMPLE_W    24                          // signed audio sample
`define SRC_COUNT_W     11                          // phase / period clock counts
`define SRC_ACC_W       (`SRC_SAMPLE_W + `SRC_COUNT_W + 2) // full precision sum

// output rate, clocks per output tick
`define SRC_OUT_DIV     512

// period thresholds for phase normalization
`define SRC_SHIFT2_LIM  384                         // below this, shift left by 2
`define SRC_SHIFT1_LIM  768                         // below this, shift left by 1

// clocks from the tick edge to out_valid
`define SRC_LATENCY     4

`endif

/* verilog/audio_pkg.sv */
`default_nettype none
`include "src_params.svh"

package audio_pkg;

    ////////////////////////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////////////////////////
    typedef logic signed [`SRC_SAMPLE_W-1:0] sample_t;   // one channel sample
    typedef logic        [`SRC_COUNT_W-1:0]  count_t;    // clock count
    typedef logic        [`SRC_COUNT_W-1:0]  weight_t;   // interpolation weight
    typedef logic signed [`SRC_ACC_W-1:0]    acc_t;      // interpolated result

    ////////////////////////////////////////////////////////////
    // composite types
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    // two-frame window plus where the output falls between them
    typedef struct packed {
        stereo_t older;                              // frame before the last strobe
        stereo_t newer;                              // frame of the last strobe
        count_t  phase;                              // clocks since the last strobe
        count_t  period;                             // clocks between last two strobes
    } window_t;

    typedef struct packed {
        acc_t left;
        acc_t right;
    } interp_frame_t;

endpackage

`default_nettype wire

/* verilog/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // interpolator sequencing
    typedef enum logic [1:0] {
        IDLE  = 2'd0,                                // wait for a window
        WEIGH = 2'd1,                                // complementary weights
        MULT  = 2'd2,                                // four products
        SUM   = 2'd3                                 // per channel sums
    } interp_state_t;

    // left shift applied to phase and period
    typedef enum logic [1:0] {
        SHIFT_0 = 2'd0,
        SHIFT_1 = 2'd1,
        SHIFT_2 = 2'd2
    } shift_sel_t;

endpackage

`default_nettype wire

/* verilog/sample_capture.sv */
`timescale 1ns/10ps
`default_nettype none
`include "src_params.svh"

// keeps the last two input frames and measures the strobe period
module sample_capture (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     in_strobe,   // one cycle, marks in_frame
    input  wire audio_pkg::stereo_t in_frame,
    output audio_pkg::window_t      history      // raw counts, not normalized
);

    localparam audio_pkg::count_t PHASE_MAX = '1;  // 2047, counter sticks here

    audio_pkg::stereo_t older_q;
    audio_pkg::stereo_t newer_q;
    audio_pkg::count_t  phase_q;                 // clocks since last strobe
    audio_pkg::count_t  period_q;                // last measured strobe spacing

    ////////////////////////////////////////////////////////////
    // frame history
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            older_q <= '0;
            newer_q <= '0;
        end else if (in_strobe) begin
            older_q <= newer_q;                  // age the previous frame
            newer_q <= in_frame;
        end
    end

    ////////////////////////////////////////////////////////////
    // strobe period counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_q  <= '0;
            period_q <= '0;
        end else if (in_strobe) begin
            period_q <= phase_q;                 // count so far is the period
            phase_q  <= '0;                      // restart on every strobe
        end else if (phase_q != PHASE_MAX) begin
            phase_q  <= phase_q + 1'b1;
        end
        // else hold, saturated for very slow inputs
    end

    // struct is a continuous level to the snapshot stage
    always_comb begin
        history.older  = older_q;
        history.newer  = newer_q;
        history.phase  = phase_q;
        history.period = period_q;
    end

endmodule

`default_nettype wire

/* verilog/phase_snapshot.sv */
`timescale 1ns/10ps
`default_nettype none
`include "src_params.svh"

// output rate divider, latches a normalized window on each tick
module phase_snapshot (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     run,
    input  wire audio_pkg::window_t history,
    output logic                    win_valid,   // one cycle after the tick edge
    output audio_pkg::window_t      win,         // held until the next tick
    output logic                    tick         // divider wrap, for the checkers
);

    localparam int DIV_W = $clog2(`SRC_OUT_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SRC_OUT_DIV - 1);

    logic [DIV_W-1:0]     div_cnt;
    ctrl_pkg::shift_sel_t shift_sel;
    audio_pkg::count_t    phase_norm;
    audio_pkg::count_t    period_norm;

    // shift left by sel, saturating if bits fall off the top
    function automatic audio_pkg::count_t norm_count(input audio_pkg::count_t val,
                                                     input ctrl_pkg::shift_sel_t sel);
        logic [`SRC_COUNT_W+1:0] wide;
        case (sel)
            ctrl_pkg::SHIFT_2: wide = {val, 2'b00};
            ctrl_pkg::SHIFT_1: wide = {1'b0, val, 1'b0};
            default:           wide = {2'b00, val};
        endcase
        if (wide[`SRC_COUNT_W+1 -: 2] != 2'b00) begin
            return '1;                           // phase only, keeps phase > period
        end
        return wide[`SRC_COUNT_W-1:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // normalization decision
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (history.period < `SRC_SHIFT2_LIM) begin
            shift_sel = ctrl_pkg::SHIFT_2;       // fast input, short period
        end else if (history.period < `SRC_SHIFT1_LIM) begin
            shift_sel = ctrl_pkg::SHIFT_1;
        end else begin
            shift_sel = ctrl_pkg::SHIFT_0;
        end
        phase_norm  = norm_count(history.phase, shift_sel);
        period_norm = norm_count(history.period, shift_sel);  // never saturates
    end

    assign tick = run && (div_cnt == DIV_LAST);

    ////////////////////////////////////////////////////////////
    // divider and window latch
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            win_valid <= 1'b0;
            win       <= '0;
        end else begin
            win_valid <= tick;
            if (!run || tick) begin
                div_cnt <= '0;                   // parked, or wrap
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (tick) begin
                win.older  <= history.older;
                win.newer  <= history.newer;
                win.phase  <= phase_norm;
                win.period <= period_norm;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/linear_interp.sv */
`timescale 1ns/10ps
`default_nettype none
`include "src_params.svh"

// older*(period-phase) + newer*phase for both channels
module linear_interp (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       win_valid,
    input  wire audio_pkg::window_t   win,       // stable from win_valid to next pulse
    output logic                      out_valid,
    output audio_pkg::interp_frame_t  out_frame  // held until the next pulse
);

    // clocks from win_valid to out_valid, one more is spent in the snapshot
    localparam int INTERP_DEPTH = 3;

    if (INTERP_DEPTH + 1 != `SRC_LATENCY) begin : g_latency_check
        $error("interpolator depth does not match SRC_LATENCY");
    end

    ctrl_pkg::interp_state_t state;
    audio_pkg::weight_t      w_older;            // weight on the older frame
    audio_pkg::weight_t      w_newer;            // weight on the newer frame
    audio_pkg::acc_t         p_old_l;
    audio_pkg::acc_t         p_new_l;
    audio_pkg::acc_t         p_old_r;
    audio_pkg::acc_t         p_new_r;

    ////////////////////////////////////////////////////////////
    // sequencer and datapath
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ctrl_pkg::IDLE;
            out_valid <= 1'b0;
            out_frame <= '0;
            w_older   <= '0;
            w_newer   <= '0;
            p_old_l   <= '0;
            p_new_l   <= '0;
            p_old_r   <= '0;
            p_new_r   <= '0;
        end else begin
            out_valid <= 1'b0;                   // pulse only out of SUM
            case (state)
                ctrl_pkg::IDLE: begin
                    if (win_valid) begin
                        state <= ctrl_pkg::WEIGH;
                    end
                end
                ctrl_pkg::WEIGH: begin
                    // no strobe for longer than the period, stay on newer
                    if (win.phase > win.period) begin
                        w_older <= '0;
                        w_newer <= win.period;
                    end else begin
                        w_older <= win.period - win.phase;
                        w_newer <= win.phase;
                    end
                    state <= ctrl_pkg::MULT;
                end
                ctrl_pkg::MULT: begin
                    // weights zero extend, samples sign extend
                    p_old_l <= audio_pkg::acc_t'(win.older.left)  * audio_pkg::acc_t'(w_older);
                    p_new_l <= audio_pkg::acc_t'(win.newer.left)  * audio_pkg::acc_t'(w_newer);
                    p_old_r <= audio_pkg::acc_t'(win.older.right) * audio_pkg::acc_t'(w_older);
                    p_new_r <= audio_pkg::acc_t'(win.newer.right) * audio_pkg::acc_t'(w_newer);
                    state   <= ctrl_pkg::SUM;
                end
                ctrl_pkg::SUM: begin
                    out_frame.left  <= p_old_l + p_new_l;  // full precision
                    out_frame.right <= p_old_r + p_new_r;
                    out_valid       <= 1'b1;
                    state           <= ctrl_pkg::IDLE;
                end
                default: begin
                    state <= ctrl_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/src_top.sv */
`timescale 1ns/10ps
`default_nettype none

// sample rate converter, capture -> snapshot -> interpolate
module src_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       run,        // enables output ticks
    input  wire                       in_strobe,
    input  wire audio_pkg::stereo_t   in_frame,
    output audio_pkg::interp_frame_t  out_frame,
    output logic                      out_valid
);

    audio_pkg::window_t history;                 // raw window, continuous
    audio_pkg::window_t win;                     // normalized, latched per tick
    logic               win_valid;
    logic               tick;                    // observed by the bound checker

    ////////////////////////////////////////////////////////////
    // producer
    ////////////////////////////////////////////////////////////
    sample_capture u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_strobe (in_strobe),
        .in_frame  (in_frame),
        .history   (history)
    );

    // output rate window latch
    phase_snapshot u_snapshot (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .history   (history),
        .win_valid (win_valid),
        .win       (win),
        .tick      (tick)
    );

    // consumer
    linear_interp u_interp (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .win       (win),
        .out_valid (out_valid),
        .out_frame (out_frame)
    );

endmodule

`default_nettype wire

/* dv/src_props.sv */
`timescale 1ns/10ps
`default_nettype none
`include "src_params.svh"

// protocol and weight checks, bound into the top level
module src_props (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          tick,       // divider wrap
    input wire                          out_valid,
    input wire audio_pkg::window_t      win,        // normalized window
    input wire ctrl_pkg::interp_state_t state,
    input wire audio_pkg::weight_t      w_older,
    input wire audio_pkg::weight_t      w_newer
);

    ////////////////////////////////////////////////////////////
    // output pulse shape and latency
    ////////////////////////////////////////////////////////////
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else $error("out_valid high for more than one clock");

    // tick is sampled at the latch edge, out_valid one edge after it rises
    a_valid_after_tick: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(tick, `SRC_LATENCY + 1))
        else $error("out_valid without a tick SRC_LATENCY clocks before");

    // every tick yields an output
    a_tick_to_valid: assert property (@(posedge clk) disable iff (!rst_n)
        $past(tick, `SRC_LATENCY + 1) |-> out_valid)
        else $error("tick not followed by out_valid");

    ////////////////////////////////////////////////////////////
    // weights, valid once WEIGH has run
    ////////////////////////////////////////////////////////////
    a_weight_sum: assert property (@(posedge clk) disable iff (!rst_n)
        state == ctrl_pkg::MULT |-> ({1'b0, w_older} + {1'b0, w_newer}) <= {1'b0, win.period})
        else $error("interpolation weights exceed the normalized period");

endmodule

bind src_top src_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .tick      (tick),
    .out_valid (out_valid),
    .win       (win),
    .state     (u_interp.state),
    .w_older   (u_interp.w_older),
    .w_newer   (u_interp.w_newer)
);

`default_nettype wire

/* dv/src_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "src_params.svh"

module src_tb;

    localparam int NUM_STROBES     = 48;
    localparam int SEG_STROBES     = 12;                 // strobes per period range
    localparam int RUN_LOW_STROBES = 3;                  // run held low this long
    localparam int PHASE_MAX       = 2047;               // capture counter sticks here
    localparam int DIV_LAST        = `SRC_OUT_DIV - 1;

    logic                     clk;
    logic                     rst_n;
    logic                     run;
    logic                     in_strobe;
    audio_pkg::stereo_t       in_frame;
    audio_pkg::interp_frame_t out_frame;
    logic                     out_valid;

    logic [15:0]        lfsr_state;
    audio_pkg::stereo_t m_older;                         // model of the capture regs
    audio_pkg::stereo_t m_newer;
    int                 m_phase;
    int                 m_period;
    int                 m_div;                           // model of the divider
    int                 cycle;                           // rising edges since reset
    longint             exp_left_q[$];
    longint             exp_right_q[$];
    int                 due_q[$];                        // cycle each output is due
    int                 gaps[NUM_STROBES];
    int                 watchdog_cycles;
    bit                 plan_ready;
    int                 mismatch_errors;
    int                 protocol_errors;
    int                 coverage_errors;
    int                 shift_hits[3];
    int                 clamp_hits;
    int                 last_out_cycle;                  // -1 until the first output

    src_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .in_strobe (in_strobe),
        .in_frame  (in_frame),
        .out_frame (out_frame),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                          // 20 ns period
    end

    ////////////////////////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_bit()};               // one step per bit
        end
        return val;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = rand_bits(16);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    function automatic audio_pkg::stereo_t random_frame();
        audio_pkg::stereo_t f;
        f.left  = audio_pkg::sample_t'(rand_bits(24));
        f.right = audio_pkg::sample_t'(rand_bits(24));
        return f;
    endfunction

    // strobe spacing, range depends on the test segment
    function automatic int pick_gap(input int idx);
        case (idx / SEG_STROBES)
            0:       return rand_range(120, 380);        // measured period < 384
            1:       return rand_range(400, 760);        // 384 .. 767
            2:       return rand_range(800, 2000);       // 768 and up
            default: return rand_range(120, 2000);       // mixed, lots of clamping
        endcase
    endfunction

    task automatic check_val(input string what, input longint actual, input longint expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s got %0d expected %0d",
                     $time, what, actual, expected);
            mismatch_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    // expected frame for a tick, from the pre-edge capture state
    task automatic predict_window();
        int     sh;
        longint ph;
        longint per;
        longint wo;
        longint wn;
        if (m_period < `SRC_SHIFT2_LIM) begin
            sh = 2;
        end else if (m_period < `SRC_SHIFT1_LIM) begin
            sh = 1;
        end else begin
            sh = 0;
        end
        shift_hits[sh]++;
        ph  = longint'(m_phase) << sh;                   // no wrap in the model
        per = longint'(m_period) << sh;
        if (ph > per) begin
            wo = 0;                                      // late strobe, all on newer
            wn = per;
            clamp_hits++;
        end else begin
            wo = per - ph;
            wn = ph;
        end
        exp_left_q.push_back(longint'(m_older.left) * wo + longint'(m_newer.left) * wn);
        exp_right_q.push_back(longint'(m_older.right) * wo + longint'(m_newer.right) * wn);
        due_q.push_back(cycle + `SRC_LATENCY);
    endtask

    // one rising edge, inputs as they were held during it
    task automatic model_edge();
        cycle++;
        if (run && m_div == DIV_LAST) begin
            predict_window();
        end
        if (!run || m_div == DIV_LAST) begin
            m_div = 0;
        end else begin
            m_div++;
        end
        if (in_strobe) begin
            m_older  = m_newer;
            m_newer  = in_frame;
            m_period = m_phase;
            m_phase  = 0;
        end else if (m_phase < PHASE_MAX) begin
            m_phase++;
        end
    endtask

    // outputs are stable at the falling edge
    task automatic check_outputs();
        longint el;
        longint er;
        int     due;
        if (out_valid) begin
            if (due_q.size() == 0) begin
                $display("%0t ns: out_valid seen with no output expected", $time);
                protocol_errors++;
            end else begin
                due = due_q.pop_front();
                el  = exp_left_q.pop_front();
                er  = exp_right_q.pop_front();
                check_val("out_valid cycle", cycle, due);
                check_val("out_frame.left", out_frame.left, el);
                check_val("out_frame.right", out_frame.right, er);
                if (last_out_cycle >= 0) begin
                    check_val("output spacing", cycle - last_out_cycle, `SRC_OUT_DIV);
                end
                last_out_cycle = cycle;
            end
        end else if (due_q.size() != 0 && cycle > due_q[0]) begin
            $display("%0t ns: out_valid missing, it was due at cycle %0d", $time, due_q[0]);
            protocol_errors++;
            void'(due_q.pop_front());
            void'(exp_left_q.pop_front());
            void'(exp_right_q.pop_front());
        end
    endtask

    task automatic step_cycle(input logic strobe, input audio_pkg::stereo_t frame,
                              input logic run_val);
        @(negedge clk);
        model_edge();
        check_outputs();
        in_strobe = strobe;                              // sampled at the next rise
        in_frame  = frame;
        run       = run_val;
    endtask

    task automatic send_strobe(input int gap, input audio_pkg::stereo_t frame,
                               input logic run_val);
        step_cycle(1'b1, frame, run_val);
        repeat (gap - 1) begin
            step_cycle(1'b0, frame, run_val);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        audio_pkg::stereo_t frame;
        int                 total_gap;
        int                 drain_end;
        rst_n     = 1'b0;
        run       = 1'b0;
        in_strobe = 1'b0;
        in_frame  = '0;
        lfsr_state      = 16'd6150;
        m_older         = '0;
        m_newer         = '0;
        m_phase         = 0;
        m_period        = 0;
        m_div           = 0;
        cycle           = 0;
        mismatch_errors = 0;
        protocol_errors = 0;
        coverage_errors = 0;
        clamp_hits      = 0;
        last_out_cycle  = -1;
        plan_ready      = 1'b0;
        for (int s = 0; s < 3; s++) begin
            shift_hits[s] = 0;
        end
        total_gap = 0;
        for (int i = 0; i < NUM_STROBES; i++) begin
            gaps[i]   = pick_gap(i);
            total_gap = total_gap + gaps[i];
        end
        watchdog_cycles = total_gap + 20 * `SRC_OUT_DIV + 16;
        plan_ready      = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_val("out_valid in reset", longint'(out_valid), 0);
        check_val("out_frame.left in reset", out_frame.left, 0);
        check_val("out_frame.right in reset", out_frame.right, 0);
        rst_n = 1'b1;

        // run rises once, after a few strobes
        for (int i = 0; i < NUM_STROBES; i++) begin
            frame = random_frame();
            send_strobe(gaps[i], frame, i >= RUN_LOW_STROBES);
        end
        if (due_q.size() != 0) begin
            drain_end = due_q[$];                        // last window still in flight
            while (cycle < drain_end) begin
                step_cycle(1'b0, in_frame, 1'b1);
            end
        end

        if (due_q.size() != 0) begin
            $display("%0d expected outputs never arrived", due_q.size());
            protocol_errors++;
        end
        for (int s = 0; s < 3; s++) begin
            if (shift_hits[s] == 0) begin
                $display("no tick was seen with a normalization shift of %0d", s);
                coverage_errors++;
            end
        end
        if (clamp_hits == 0) begin
            $display("no tick was seen with the phase beyond the period");
            coverage_errors++;
        end
        $display("errors: %0d mismatch, %0d protocol, %0d coverage",
                 mismatch_errors, protocol_errors, coverage_errors);
        if (mismatch_errors + protocol_errors + coverage_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // bound by the planned strobe gaps plus 20 output periods
    initial begin : watchdog
        wait (plan_ready);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d clocks, the run did not finish", watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verilog
verilog/audio_pkg.sv
verilog/ctrl_pkg.sv
verilog/sample_capture.sv
verilog/phase_snapshot.sv
verilog/linear_interp.sv
verilog/src_top.sv
dv/src_props.sv
dv/src_tb.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= src_tb
FILELIST ?= sources.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, the binary status is not used
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
